// ==== elev_macros.svh ====
// shared sizing for the car controller; ELEV_FLOOR_W must be wide enough for ELEV_NUM_FLOORS-1
`ifndef ELEV_MACROS_SVH
`define ELEV_MACROS_SVH

// building size
`define ELEV_NUM_FLOORS 8

// floor index width as log2 of the floor count
`define ELEV_FLOOR_W 3

// cycles the door stays open, kept below 256 by the 8-bit dwell counter
`define ELEV_DWELL_CYCLES 10

`endif

// ==== elev_motion_pkg.sv ====
// car motion types; floor masks are one bit per floor with bit 0 at the ground floor
`default_nettype none

`include "elev_macros.svh"

package elev_motion_pkg;

	typedef logic [`ELEV_NUM_FLOORS-1:0] floor_mask_t;	// one request bit per floor
	typedef logic [`ELEV_FLOOR_W-1:0] floor_t;		// floor index

	typedef enum logic {
		DIR_DOWN = 1'b0,
		DIR_UP   = 1'b1
	} dir_e;

	// motor command in the same coding the drive expects
	typedef enum logic [1:0] {
		ENG_IDLE = 2'd0,
		ENG_DOWN = 2'd1,
		ENG_UP   = 2'd2
	} engine_e;

	typedef enum logic [1:0] {
		T_PARKED  = 2'd0,	// stopped and choosing the next move
		T_MOVING  = 2'd1,	// engine running between floors
		T_SERVING = 2'd2	// stopped for door service
	} travel_state_e;

endpackage

`default_nettype wire

// ==== elev_door_pkg.sv ====
// door types; the sensor coding follows the door drive which never reports 3
`default_nettype none

package elev_door_pkg;

	typedef enum logic [1:0] {
		DOOR_IDLE  = 2'd0,
		DOOR_OPEN  = 2'd1,
		DOOR_CLOSE = 2'd2
	} door_cmd_e;

	typedef enum logic [1:0] {
		SENSE_BETWEEN = 2'd0,
		SENSE_OPEN    = 2'd1,
		SENSE_CLOSED  = 2'd2
	} door_sense_e;

	typedef enum logic [1:0] {D_IDLE, D_OPENING, D_DWELL, D_CLOSING} door_state_e;

endpackage

`default_nettype wire

// ==== request_if.sv ====
// pending masks and clear commands between request storage and dispatch; clears are one-cycle pulses
`default_nettype none
`timescale 1ns/1ps

interface request_if;
	import elev_motion_pkg::*;

	floor_mask_t car_pending;	// car buttons
	floor_mask_t up_pending;	// hall up buttons
	floor_mask_t down_pending;	// hall down buttons

	logic   clr_valid;		// one-cycle clear strobe
	floor_t clr_floor;		// floor being served
	logic   clr_up;			// also drop hall up there
	logic   clr_down;		// also drop hall down there

	modport store (
		output car_pending, up_pending, down_pending,
		input  clr_valid, clr_floor, clr_up, clr_down
	);

	modport dispatch (
		input  car_pending, up_pending, down_pending,
		output clr_valid, clr_floor, clr_up, clr_down
	);

endinterface

`default_nettype wire

// ==== request_regs.sv ====
// sticky button latches; a press in the same cycle as its clear keeps the request pending
`default_nettype none
`timescale 1ns/1ps

`include "elev_macros.svh"

module request_regs (
	input  logic                         clk,
	input  logic                         reset,
	input  elev_motion_pkg::floor_mask_t i_btn_car,
	input  elev_motion_pkg::floor_mask_t i_btn_up,
	input  elev_motion_pkg::floor_mask_t i_btn_down,
	request_if.store                     req
);
	import elev_motion_pkg::*;

	floor_mask_t clr_bit;
	floor_mask_t up_exists;
	floor_mask_t down_exists;

	function automatic floor_mask_t next_mask(input floor_mask_t cur, input floor_mask_t clr,
			input floor_mask_t press, input floor_mask_t exists);
		return ((cur & ~clr) | press) & exists;
	endfunction

	assign clr_bit     = req.clr_valid ? (floor_mask_t'(1) << req.clr_floor) : '0;
	assign up_exists   = ~(floor_mask_t'(1) << (`ELEV_NUM_FLOORS - 1));	// no up button on top
	assign down_exists = ~floor_mask_t'(1);				// no down button at ground

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			req.car_pending  <= '0;
			req.up_pending   <= '0;
			req.down_pending <= '0;
		end else begin
			req.car_pending  <= next_mask(req.car_pending, clr_bit, i_btn_car, '1);
			req.up_pending   <= next_mask(req.up_pending, req.clr_up ? clr_bit : '0,
				i_btn_up, up_exists);
			req.down_pending <= next_mask(req.down_pending, req.clr_down ? clr_bit : '0,
				i_btn_down, down_exists);
		end
	end

	// dispatch relies on this to never target a missing button
	a_no_up_at_top: assert property (@(posedge clk) disable iff (!reset)
		!req.up_pending[`ELEV_NUM_FLOORS-1]);

endmodule

`default_nettype wire

// ==== car_dispatch.sv ====
// sweep dispatcher; the reached pulse must drop between floors or the next arrival is missed
`default_nettype none
`timescale 1ns/1ps

`include "elev_macros.svh"

module car_dispatch (
	input  logic                     clk,
	input  logic                     reset,
	request_if.dispatch              req,
	input  logic                     i_sensor_up,
	input  logic                     i_sensor_down,
	input  logic                     i_svc_ready,
	input  logic                     i_door_busy,
	output logic                     o_svc_valid,
	output elev_motion_pkg::engine_e o_engine,
	output elev_motion_pkg::dir_e    o_direction,
	output elev_motion_pkg::floor_t  o_level
);
	import elev_motion_pkg::*;

	travel_state_e state;
	logic          reached_q;		// previous reached sample
	logic          arrived;		// level just stepped so the stop rule applies

	floor_mask_t any_pending;
	floor_mask_t here_bit;
	floor_mask_t below_mask;
	floor_mask_t above_mask;
	logic        reached;
	logic        reached_edge;
	logic        pend_above;
	logic        pend_below;
	logic        ahead;
	logic        behind;
	logic        here_car;
	logic        here_up;
	logic        here_down;
	logic        stop_here;
	logic        turn;
	logic        serve_now;

	assign reached      = i_sensor_up & i_sensor_down;
	assign reached_edge = reached & ~reached_q;

	assign any_pending = req.car_pending | req.up_pending | req.down_pending;
	assign here_bit    = floor_mask_t'(1) << o_level;
	assign below_mask  = here_bit - floor_mask_t'(1);
	assign above_mask  = ~(below_mask | here_bit);
	assign pend_above  = |(any_pending & above_mask);
	assign pend_below  = |(any_pending & below_mask);
	assign ahead       = (o_direction == DIR_UP) ? pend_above : pend_below;
	assign behind      = (o_direction == DIR_UP) ? pend_below : pend_above;

	assign here_car  = req.car_pending[o_level];
	assign here_up   = req.up_pending[o_level];
	assign here_down = req.down_pending[o_level];

	// hall call against the sweep only counts when nothing lies further on
	assign stop_here = here_car | ((o_direction == DIR_UP) ?
		(here_up | (here_down & ~ahead)) : (here_down | (here_up & ~ahead)));
	assign turn      = ~ahead & (behind | ((o_direction == DIR_UP) ? here_down : here_up));

	assign serve_now = stop_here & ((state == T_PARKED && !i_door_busy) ||
		(state == T_MOVING && arrived));

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state         <= T_PARKED;
			o_engine      <= ENG_IDLE;
			o_direction   <= DIR_UP;
			o_level       <= '0;
			o_svc_valid   <= 1'b0;
			reached_q     <= 1'b0;
			arrived       <= 1'b0;
			req.clr_valid <= 1'b0;
			req.clr_floor <= '0;
			req.clr_up    <= 1'b0;
			req.clr_down  <= 1'b0;
		end else begin
			reached_q     <= reached;
			arrived       <= 1'b0;
			req.clr_valid <= 1'b0;
			if (serve_now) begin
				state         <= T_SERVING;
				o_engine      <= ENG_IDLE;
				o_svc_valid   <= 1'b1;
				req.clr_valid <= 1'b1;
				req.clr_floor <= o_level;
				req.clr_up    <= (o_direction == DIR_UP) | ~ahead;	// both halls on a turn
				req.clr_down  <= (o_direction == DIR_DOWN) | ~ahead;
				if (turn)
					o_direction <= (o_direction == DIR_UP) ? DIR_DOWN : DIR_UP;
			end else begin
				case (state)
					T_PARKED: begin
						if (!i_door_busy && ahead) begin
							state    <= T_MOVING;
							o_engine <= (o_direction == DIR_UP) ? ENG_UP : ENG_DOWN;
						end else if (!i_door_busy && behind) begin
							state       <= T_MOVING;	// reverse and go
							o_direction <= (o_direction == DIR_UP) ? DIR_DOWN : DIR_UP;
							o_engine    <= (o_direction == DIR_UP) ? ENG_DOWN : ENG_UP;
						end
					end
					T_MOVING: begin
						if (reached_edge) begin
							o_level <= (o_engine == ENG_UP) ? o_level + 1'b1 : o_level - 1'b1;
							arrived <= 1'b1;
						end else if (arrived && !ahead) begin
							state    <= T_PARKED;	// nothing left to chase
							o_engine <= ENG_IDLE;
						end
					end
					T_SERVING: begin
						if (o_svc_valid && i_svc_ready) begin
							o_svc_valid <= 1'b0;
							state       <= T_PARKED;
						end
					end
					default: state <= T_PARKED;
				endcase
			end
		end
	end

	a_idle_door_busy: assert property (@(posedge clk) disable iff (!reset)
		i_door_busy |-> o_engine == ENG_IDLE);

	// a floor step never runs past either end of the shaft
	a_level_range: assert property (@(posedge clk) disable iff (!reset)
		(state == T_MOVING && reached_edge) |-> ((o_engine == ENG_UP) ?
		(o_level != floor_t'(`ELEV_NUM_FLOORS - 1)) : (o_level != '0)));

endmodule

`default_nettype wire

// ==== door_ctrl.sv ====
// door sequencer; the door sensor must stay closed while the command is idle
`default_nettype none
`timescale 1ns/1ps

`include "elev_macros.svh"

module door_ctrl (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       i_svc_valid,
	input  elev_door_pkg::door_sense_e i_sensor_door,
	input  logic                       i_sensor_inside,
	input  logic                       i_overload,
	input  logic                       i_open_btn,
	output elev_door_pkg::door_cmd_e   o_door,
	output logic                       o_svc_ready,
	output logic                       o_door_busy
);
	import elev_door_pkg::*;

	door_state_e state;
	logic [7:0]  dwell_cnt;
	logic        reopen;

	assign reopen      = i_sensor_inside | i_overload | i_open_btn;
	assign o_door_busy = (state != D_IDLE);

	always_comb begin
		case (state)
			D_OPENING: o_door = DOOR_OPEN;
			D_CLOSING: o_door = DOOR_CLOSE;
			default:   o_door = DOOR_IDLE;	// motor off while idle or dwelling
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state       <= D_IDLE;
			dwell_cnt   <= '0;
			o_svc_ready <= 1'b0;
		end else begin
			o_svc_ready <= 1'b0;
			case (state)
				D_IDLE: begin
					// valid is still high in the handshake cycle
					if (i_svc_valid && !o_svc_ready)
						state <= D_OPENING;
				end
				D_OPENING: begin
					if (i_sensor_door == SENSE_OPEN) begin
						state     <= D_DWELL;
						dwell_cnt <= '0;
					end
				end
				D_DWELL: begin
					dwell_cnt <= dwell_cnt + 8'd1;
					if (dwell_cnt == 8'(`ELEV_DWELL_CYCLES - 1))
						state <= D_CLOSING;
				end
				D_CLOSING: begin
					if (reopen) begin
						state <= D_OPENING;	// obstruction, overload or open button
					end else if (i_sensor_door == SENSE_CLOSED) begin
						state       <= D_IDLE;
						o_svc_ready <= 1'b1;
					end
				end
				default: state <= D_IDLE;
			endcase
		end
	end

	a_ready_closed: assert property (@(posedge clk) disable iff (!reset)
		o_svc_ready |-> i_sensor_door == SENSE_CLOSED);

endmodule

`default_nettype wire

// ==== elevator_top.sv ====
// single car controller; hall up at the top floor and hall down at floor 0 are ignored
`default_nettype none
`timescale 1ns/1ps

module elevator_top (
	input  logic                         clk,
	input  logic                         reset,
	input  elev_motion_pkg::floor_mask_t i_btn_car,
	input  elev_motion_pkg::floor_mask_t i_btn_up,
	input  elev_motion_pkg::floor_mask_t i_btn_down,
	input  logic                         i_sensor_up,
	input  logic                         i_sensor_down,
	input  elev_door_pkg::door_sense_e   i_sensor_door,
	input  logic                         i_sensor_inside,
	input  logic                         i_overload,
	input  logic                         i_open_btn,
	output elev_motion_pkg::engine_e     o_engine,
	output elev_door_pkg::door_cmd_e     o_door,
	output elev_motion_pkg::dir_e        o_direction,
	output elev_motion_pkg::floor_t      o_level
);

	logic svc_valid;		// stop service request
	logic svc_ready;		// door cycle finished
	logic door_busy;		// holds the engine off

	request_if req_bus ();

	request_regs u_request_regs (
		.clk        (clk),
		.reset      (reset),
		.i_btn_car  (i_btn_car),
		.i_btn_up   (i_btn_up),
		.i_btn_down (i_btn_down),
		.req        (req_bus.store)
	);

	car_dispatch u_car_dispatch (
		.clk           (clk),
		.reset         (reset),
		.req           (req_bus.dispatch),
		.i_sensor_up   (i_sensor_up),
		.i_sensor_down (i_sensor_down),
		.i_svc_ready   (svc_ready),
		.i_door_busy   (door_busy),
		.o_svc_valid   (svc_valid),
		.o_engine      (o_engine),
		.o_direction   (o_direction),
		.o_level       (o_level)
	);

	door_ctrl u_door_ctrl (
		.clk             (clk),
		.reset           (reset),
		.i_svc_valid     (svc_valid),
		.i_sensor_door   (i_sensor_door),
		.i_sensor_inside (i_sensor_inside),
		.i_overload      (i_overload),
		.i_open_btn      (i_open_btn),
		.o_door          (o_door),
		.o_svc_ready     (svc_ready),
		.o_door_busy     (door_busy)
	);

endmodule

`default_nettype wire

// ==== tb_elevator.sv ====
// expects a parked car between rows and a plant that pulses reached once per 6 moving cycles
`default_nettype none
`timescale 1ns/1ps

`include "elev_macros.svh"

module tb_elevator;
	import elev_motion_pkg::*;
	import elev_door_pkg::*;

	localparam int NUM_ROWS = 8;
	localparam int LIMIT = NUM_ROWS * 8 * (6 + 40 + `ELEV_DWELL_CYCLES) + NUM_ROWS * 60 + 20;

	logic clk;
	logic reset;
	floor_mask_t i_btn_car;
	floor_mask_t i_btn_up;
	floor_mask_t i_btn_down;
	logic i_sensor_up;
	logic i_sensor_down;
	door_sense_e i_sensor_door;
	logic i_sensor_inside;
	logic i_overload;
	logic i_open_btn;
	engine_e o_engine;
	door_cmd_e o_door;
	dir_e o_direction;
	floor_t o_level;

	logic [7:0] row_car [NUM_ROWS];	// stimulus table
	logic [7:0] row_up [NUM_ROWS];
	logic [7:0] row_down [NUM_ROWS];
	logic row_obs [NUM_ROWS];

	int exp_q[$];			// expected stop floors
	int got_q[$];			// floors where the door opened
	int m_level;			// reference car position
	logic m_dir;			// reference sweep direction with 1 for up
	int errors;
	int checks;
	int cycles;
	int track_lvl;
	logic pulse_seen;
	logic pulse_up;
	door_cmd_e prev_door;
	door_cmd_e last_cmd;
	int shaft_cnt;
	int door_cnt;
	int inside_cnt;
	logic obs_active;
	logic obs_done;
	logic reopened;
	logic [31:0] seed;

	elevator_top dut (
		.clk             (clk),
		.reset           (reset),
		.i_btn_car       (i_btn_car),
		.i_btn_up        (i_btn_up),
		.i_btn_down      (i_btn_down),
		.i_sensor_up     (i_sensor_up),
		.i_sensor_down   (i_sensor_down),
		.i_sensor_door   (i_sensor_door),
		.i_sensor_inside (i_sensor_inside),
		.i_overload      (i_overload),
		.i_open_btn      (i_open_btn),
		.o_engine        (o_engine),
		.o_door          (o_door),
		.o_direction     (o_direction),
		.o_level         (o_level)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// sweep reference that carries position and direction across rows
	task automatic build_expected(input logic [7:0] car_in, input logic [7:0] up_in,
			input logic [7:0] down_in);
		logic [7:0] car;
		logic [7:0] up;
		logic [7:0] down;
		logic [7:0] all;
		logic [7:0] here;
		logic [7:0] below;
		logic [7:0] above;
		logic ahead;
		logic behind;
		logic stop;
		logic turn;
		int guard;
		car = car_in;
		up = up_in & 8'h7f;		// no up button on top
		down = down_in & 8'hfe;		// no down button at ground
		guard = 0;
		all = car | up | down;
		while (all != 8'h00 && guard < 64) begin
			here = 8'h01 << m_level;
			below = here - 8'h01;
			above = ~(below | here);
			ahead = m_dir ? |(all & above) : |(all & below);
			behind = m_dir ? |(all & below) : |(all & above);
			if (m_dir)
				stop = car[m_level] | up[m_level] | (down[m_level] & !ahead);
			else
				stop = car[m_level] | down[m_level] | (up[m_level] & !ahead);
			if (stop) begin
				turn = !ahead && (behind || (m_dir ? down[m_level] : up[m_level]));
				exp_q.push_back(m_level);
				car[m_level] = 1'b0;
				if (m_dir || !ahead)
					up[m_level] = 1'b0;
				if (!m_dir || !ahead)
					down[m_level] = 1'b0;
				if (turn)
					m_dir = !m_dir;
			end else if (ahead) begin
				m_level = m_dir ? m_level + 1 : m_level - 1;
			end else begin
				m_dir = !m_dir;	// only requests behind
			end
			all = car | up | down;
			guard++;
		end
	endtask

	// shaft and door plant driven just after the edge
	always @(posedge clk) begin
		#1;
		if (!reset) begin
			shaft_cnt = 0;
			door_cnt = 0;
			inside_cnt = 0;
			last_cmd = DOOR_IDLE;
		end else begin
			if (o_engine == ENG_IDLE) begin
				shaft_cnt = 0;
				i_sensor_up = 1'b0;
				i_sensor_down = 1'b0;
			end else if (shaft_cnt == 5) begin
				shaft_cnt = 0;
				i_sensor_up = 1'b1;
				i_sensor_down = 1'b1;
			end else begin
				shaft_cnt++;
				i_sensor_up = 1'b0;
				i_sensor_down = 1'b0;
			end
			if (o_door != last_cmd)
				door_cnt = 0;
			last_cmd = o_door;
			if (o_door == DOOR_OPEN) begin
				door_cnt++;
				i_sensor_door = (door_cnt >= 3) ? SENSE_OPEN : SENSE_BETWEEN;
			end else if (o_door == DOOR_CLOSE) begin
				door_cnt++;
				i_sensor_door = (door_cnt >= 3) ? SENSE_CLOSED : SENSE_BETWEEN;
			end
			if (obs_active && !obs_done && o_door == DOOR_CLOSE) begin
				inside_cnt = 2;		// block the first close of the row
				obs_done = 1'b1;
			end
			i_sensor_inside = (inside_cnt > 0);
			if (inside_cnt > 0)
				inside_cnt--;
		end
	end

	// per-cycle monitor at the falling edge where outputs are settled
	always @(negedge clk) begin
		if (reset) begin
			if (pulse_seen)
				track_lvl = pulse_up ? track_lvl + 1 : track_lvl - 1;
			pulse_seen = 1'b0;
			if (i_sensor_up && i_sensor_down) begin
				pulse_seen = 1'b1;
				pulse_up = (o_engine == ENG_UP);
			end
			check("o_level", 32'(o_level), 32'(track_lvl));
			if (o_door != DOOR_IDLE || i_sensor_door != SENSE_CLOSED)
				check("o_engine", 32'(o_engine), 32'(ENG_IDLE));
			if (prev_door == DOOR_IDLE && o_door == DOOR_OPEN)
				got_q.push_back(int'(o_level));
			if (prev_door == DOOR_CLOSE && o_door == DOOR_OPEN)
				reopened = 1'b1;
			prev_door = o_door;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Timeout after %0d cycles, the car did not finish its stops", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b0;
		i_btn_car = '0;
		i_btn_up = '0;
		i_btn_down = '0;
		i_sensor_up = 1'b0;
		i_sensor_down = 1'b0;
		i_sensor_door = SENSE_CLOSED;
		i_sensor_inside = 1'b0;
		i_overload = 1'b0;
		i_open_btn = 1'b0;
		errors = 0;
		checks = 0;
		cycles = 0;
		track_lvl = 0;
		pulse_seen = 1'b0;
		pulse_up = 1'b0;
		prev_door = DOOR_IDLE;
		obs_active = 1'b0;
		obs_done = 1'b0;
		reopened = 1'b0;
		m_level = 0;
		m_dir = 1'b1;
		seed = 32'hf8c11892;

		// fixed rows cover a top reversal, an obstruction, mixed halls and a car call
		{row_car[0], row_up[0], row_down[0], row_obs[0]} = {8'h20, 8'h04, 8'h10, 1'b0};
		{row_car[1], row_up[1], row_down[1], row_obs[1]} = {8'h01, 8'h00, 8'h00, 1'b1};
		{row_car[2], row_up[2], row_down[2], row_obs[2]} = {8'h08, 8'h40, 8'h84, 1'b0};
		{row_car[3], row_up[3], row_down[3], row_obs[3]} = {8'h04, 8'h00, 8'h02, 1'b0};
		for (int i = 4; i < NUM_ROWS; i++) begin
			seed = lcg_next(seed);
			row_car[i] = seed[7:0] & seed[15:8];
			row_up[i] = seed[23:16] & seed[31:24];
			seed = lcg_next(seed);
			row_down[i] = seed[7:0] & seed[15:8] & seed[23:16];
			row_obs[i] = 1'b0;
		end

		repeat (4) @(posedge clk);
		#1 reset = 1'b1;

		for (int r = 0; r < NUM_ROWS; r++) begin
			exp_q.delete();
			got_q.delete();
			obs_active = row_obs[r];
			obs_done = 1'b0;
			reopened = 1'b0;
			build_expected(row_car[r], row_up[r], row_down[r]);
			@(posedge clk);
			#1;
			i_btn_car = row_car[r];
			i_btn_up = row_up[r];
			i_btn_down = row_down[r];
			@(posedge clk);
			#1;
			i_btn_car = '0;
			i_btn_up = '0;
			i_btn_down = '0;
			@(negedge clk);
			while (got_q.size() < exp_q.size() || o_door != DOOR_IDLE ||
					i_sensor_door != SENSE_CLOSED || o_engine != ENG_IDLE)
				@(negedge clk);
			repeat (50) begin	// parked with nothing left
				@(negedge clk);
				check("o_engine", 32'(o_engine), 32'(ENG_IDLE));
				check("o_door", 32'(o_door), 32'(DOOR_IDLE));
			end
			check("stop count", 32'(got_q.size()), 32'(exp_q.size()));
			for (int k = 0; k < exp_q.size() && k < got_q.size(); k++)
				check("stop floor", 32'(got_q[k]), 32'(exp_q[k]));
			check("o_level", 32'(o_level), 32'(m_level));
			check("o_direction", 32'(o_direction), 32'(m_dir));
			if (row_obs[r] && !reopened) begin
				errors++;
				$display("Row %0d: the door did not reopen after the obstruction", r);
			end
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
elev_motion_pkg.sv
elev_door_pkg.sv
request_if.sv
request_regs.sv
car_dispatch.sv
door_ctrl.sv
elevator_top.sv
tb_elevator.sv

// ==== run.sh ====
#!/bin/sh
# build and run the elevator testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module tb_elevator
./obj_dir/Vtb_elevator > sim.log 2>&1 || true
cat sim.log
if grep -q "All tests passed!" sim.log; then
	exit 0
fi
exit 1
